// ==== vlog.f ====
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_mul.sv
hdl/exec_pipe_reg.sv
hdl/exec_stage.sv
testbench/tb_exec_stage.sv

// ==== testbench/tb_exec_stage.sv ====
`timescale 1ns/1ps

module tb_exec_stage;

	import exec_pkg::*;

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	logic                 in_ready;
	logic [addr_w-1:0]    pc;
	logic [op_w-1:0]      alu_op;
	logic [xlen-1:0]      src_a;
	logic [xlen-1:0]      src_b;
	logic [xlen-1:0]      store_data;
	logic                 is_branch;
	logic [bimm_w-1:0]    branch_imm;
	logic                 mem_write;
	logic                 wb_sel;
	logic                 reg_write;
	logic [reg_idx_w-1:0] rdest;
	logic                 out_valid;
	logic                 out_ready;
	logic [addr_w-1:0]    out_pc;
	exec_word_u           out_result;
	logic [xlen-1:0]      out_store_data;
	logic                 out_mem_write;
	logic                 out_wb_sel;
	logic                 out_reg_write;
	logic [reg_idx_w-1:0] out_rdest;
	logic                 branch_taken;
	logic [addr_w-1:0]    branch_target;

	integer seed = 32'h0c95_7920;
	logic bp_mode = 1'b0; // random out_ready stretches
	int n_in = 0;
	int n_out = 0;
	logic [addr_w-1:0] exp_pc[$];
	exec_word_u exp_res[$];
	logic [xlen-1:0] exp_store[$];
	logic [7:0] exp_side[$]; // mem_write, wb_sel, reg_write, rdest
	bit exp_is_mul[$];

	exec_stage u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run;
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		stop_run();
	endtask

	task automatic check_result(input string name, input exec_word_u got, input exec_word_u exp);
		if (got.dword !== exp.dword) begin
			$display("FAIL %s: got %h expected %h", name, got.dword, exp.dword);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [addr_w-1:0] got,
		input logic [addr_w-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_idx(input string name, input logic [reg_idx_w-1:0] got,
		input logic [reg_idx_w-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [xlen-1:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic bit is_mul_op(input logic [op_w-1:0] op);
		return op >= op_mul && op <= op_mulw;
	endfunction

	function automatic exec_word_u exec_model(input logic [op_w-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		exec_word_u r;
		logic [31:0] w; // word result before sign extension
		logic [2*xlen-1:0] sp;
		logic [2*xlen-1:0] up;
		r.dword = '0;
		w = '0;
		sp = $signed({{xlen{a[xlen-1]}}, a}) * $signed({{xlen{b[xlen-1]}}, b});
		up = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
		case (op)
			op_add:   r.dword = a + b;
			op_addw:  w = a[31:0] + b[31:0];
			op_sll:   r.dword = a << b[5:0];
			op_sllw:  w = a[31:0] << b[4:0];
			op_sra:   r.dword = $signed(a) >>> b[5:0];
			op_sraw:  w = $signed(a[31:0]) >>> b[4:0];
			op_srl:   r.dword = a >> b[5:0];
			op_srlw:  w = a[31:0] >> b[4:0];
			op_and:   r.dword = a & b;
			op_or:    r.dword = a | b;
			op_xor:   r.dword = a ^ b;
			op_slt:   r.dword = xlen'($signed(a) < $signed(b));
			op_sltu:  r.dword = xlen'(a < b);
			op_eq:    r.dword = xlen'(a == b);
			op_ne:    r.dword = xlen'(a != b);
			op_ge:    r.dword = xlen'($signed(a) >= $signed(b));
			op_geu:   r.dword = xlen'(a >= b);
			op_sub:   r.dword = a - b;
			op_subw:  w = a[31:0] - b[31:0];
			op_mul:   r.dword = up[xlen-1:0];
			op_mulh:  r.dword = sp[2*xlen-1:xlen];
			op_mulhu: r.dword = up[2*xlen-1:xlen];
			op_mulw:  w = up[31:0]; // low word same for any signedness
			default:  r.dword = '0; // divide codes and spares
		endcase
		if (op inside {op_addw, op_sllw, op_sraw, op_srlw, op_subw, op_mulw}) begin
			r.dword = {{32{w[31]}}, w};
		end
		return r;
	endfunction

	task automatic send_item(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
		exec_word_u exp_w;
		logic [addr_w-1:0] target;
		int waited;
		waited = 0;
		alu_op = op;
		src_a = a;
		src_b = b;
		pc = rand64() & ~64'h3;
		store_data = rand64();
		is_branch = is_mul_op(op) ? 1'b0 : 1'($random(seed));
		branch_imm = bimm_w'($random(seed));
		{mem_write, wb_sel, reg_write, rdest} = 8'($random(seed));
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready) begin
			waited++;
			if (waited > 500) report_timeout("in_ready to accept an item");
			@(negedge clk);
		end
		// transfer happens on the coming edge
		exp_w = exec_model(op, a, b);
		target = pc + (addr_w'($signed(branch_imm)) << 1);
		check_addr("branch_target", branch_target, target);
		check_bit("branch_taken", branch_taken, is_branch && (exp_w.dword != '0));
		exp_pc.push_back(pc);
		exp_res.push_back(exp_w);
		exp_store.push_back(store_data);
		exp_side.push_back({mem_write, wb_sel, reg_write, rdest});
		exp_is_mul.push_back(is_mul_op(op));
		n_in++;
		@(posedge clk);
		#10;
		in_valid = 1'b0;
	endtask

	initial begin
		int stretch;
		logic next_ready;
		stretch = 0;
		next_ready = 1'b1;
		forever begin
			@(posedge clk);
			if (!bp_mode) begin
				next_ready = 1'b1;
			end else if (stretch == 0) begin
				next_ready = ~next_ready;
				stretch = $unsigned($random(seed)) % 6;
			end else begin
				stretch--;
			end
			#10;
			out_ready = next_ready;
		end
	end

	// checker samples mid-cycle
	initial begin
		logic stalled;
		logic mul_inflight;
		logic alu_pending;
		logic [addr_w-1:0] snap_pc;
		exec_word_u snap_res;
		logic [xlen-1:0] snap_store;
		logic [7:0] snap_side;
		logic [7:0] side;
		stalled = 1'b0;
		mul_inflight = 1'b0;
		alu_pending = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset) begin
				if (stalled) begin
					check_bit("out_valid", out_valid, 1'b1);
					check_addr("out_pc", out_pc, snap_pc);
					check_result("out_result", out_result, snap_res);
					check_data("out_store_data", out_store_data, snap_store);
					check_bit("out_mem_write", out_mem_write, snap_side[7]);
					check_bit("out_wb_sel", out_wb_sel, snap_side[6]);
					check_bit("out_reg_write", out_reg_write, snap_side[5]);
					check_idx("out_rdest", out_rdest, snap_side[4:0]);
				end
				// single-cycle result one edge after acceptance
				if (alu_pending) begin
					check_bit("out_valid", out_valid, 1'b1);
				end
				if (out_valid && !out_ready) begin
					check_bit("in_ready", in_ready, 1'b0);
				end
				// input held off until the product shows
				if (mul_inflight) begin
					if (out_valid && exp_is_mul.size() > 0 && exp_is_mul[0]) begin
						mul_inflight = 1'b0;
					end else begin
						check_bit("in_ready", in_ready, 1'b0);
					end
				end
				if (out_valid && out_ready) begin
					if (exp_res.size() == 0) begin
						$display("ERROR: output transfer with no item outstanding");
						stop_run();
					end else begin
						side = exp_side.pop_front();
						check_addr("out_pc", out_pc, exp_pc.pop_front());
						check_result("out_result", out_result, exp_res.pop_front());
						check_data("out_store_data", out_store_data, exp_store.pop_front());
						check_bit("out_mem_write", out_mem_write, side[7]);
						check_bit("out_wb_sel", out_wb_sel, side[6]);
						check_bit("out_reg_write", out_reg_write, side[5]);
						check_idx("out_rdest", out_rdest, side[4:0]);
						void'(exp_is_mul.pop_front());
						n_out++;
					end
				end
				if (in_valid && in_ready && is_mul_op(alu_op)) begin
					mul_inflight = 1'b1;
				end
				alu_pending = in_valid && in_ready && !is_mul_op(alu_op);
				stalled = out_valid && !out_ready;
				snap_pc = out_pc;
				snap_res = out_result;
				snap_store = out_store_data;
				snap_side = {out_mem_write, out_wb_sel, out_reg_write, out_rdest};
			end
		end
	end

	initial begin
		int op;
		int k;
		int waited;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] mul_a[4];
		logic [xlen-1:0] mul_b[4];
		mul_a = '{64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
			-64'sd12345, 64'hffff_ffff_ffff_fffe};
		mul_b = '{64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
			64'd98765, 64'hffff_ffff_0000_0001};
		reset = 1'b1;
		in_valid = 1'b0;
		pc = '0;
		alu_op = '0;
		src_a = '0;
		src_b = '0;
		store_data = '0;
		is_branch = 1'b0;
		branch_imm = '0;
		mem_write = 1'b0;
		wb_sel = 1'b0;
		reg_write = 1'b0;
		rdest = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clk);
		#10;
		reset = 1'b0;
		@(negedge clk);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("in_ready", in_ready, 1'b1);
		@(posedge clk);
		#10;
		for (op = 0; op <= 18; op++) begin
			for (k = 0; k < 12; k++) begin
				a = rand64();
				b = rand64();
				if (k % 2) b = b & 64'h7f; // shift amounts 0..127
				send_item(op_w'(op), a, b);
			end
		end
		for (op = op_mul; op <= op_mulw; op++) begin
			for (k = 0; k < 6; k++) begin
				a = (k < 4) ? mul_a[k] : rand64();
				b = (k < 4) ? mul_b[k] : rand64();
				send_item(op_w'(op), a, b);
			end
		end
		for (op = 23; op <= 31; op++) begin
			for (k = 0; k < 2; k++) begin
				a = rand64();
				b = rand64();
				send_item(op_w'(op), a, b);
			end
		end
		bp_mode = 1'b1;
		repeat (80) begin
			op = $unsigned($random(seed)) % 32;
			a = rand64();
			b = rand64();
			send_item(op_w'(op), a, b);
			if (($random(seed) & 3) == 0) begin
				@(posedge clk);
				#10;
			end
		end
		bp_mode = 1'b0;
		waited = 0;
		while (n_out != n_in) begin
			waited++;
			if (waited > 1000) report_timeout("outstanding results to drain");
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		if (n_out == n_in && exp_res.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("ERROR: %0d items sent but %0d results seen", n_in, n_out);
			stop_run();
		end
	end

endmodule

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  logic [exec_pkg::addr_w-1:0]    pc,
	input  logic [exec_pkg::op_w-1:0]      alu_op,
	input  logic [exec_pkg::xlen-1:0]      src_a,
	input  logic [exec_pkg::xlen-1:0]      src_b,
	input  logic [exec_pkg::xlen-1:0]      store_data,
	input  logic                           is_branch,
	input  logic [exec_pkg::bimm_w-1:0]    branch_imm,
	input  logic                           mem_write,
	input  logic                           wb_sel,      // 0 result, 1 load data
	input  logic                           reg_write,
	input  logic [exec_pkg::reg_idx_w-1:0] rdest,
	output logic                           out_valid,
	input  logic                           out_ready,
	output logic [exec_pkg::addr_w-1:0]    out_pc,
	output exec_pkg::exec_word_u           out_result,
	output logic [exec_pkg::xlen-1:0]      out_store_data,
	output logic                           out_mem_write,
	output logic                           out_wb_sel,
	output logic                           out_reg_write,
	output logic [exec_pkg::reg_idx_w-1:0] out_rdest,
	output logic                           branch_taken,  // valid with in_valid
	output logic [exec_pkg::addr_w-1:0]    branch_target
);

	import exec_pkg::*;

	exec_word_u alu_result;
	exec_word_u mul_product;
	logic       mul_start;
	logic       mul_busy;
	logic       mul_done;

	exec_alu u_alu (
		.alu_op        (alu_op),
		.src_a         (src_a),
		.src_b         (src_b),
		.pc            (pc),
		.is_branch     (is_branch),
		.branch_imm    (branch_imm),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	exec_mul u_mul (
		.clk         (clk),
		.reset       (reset),
		.mul_start   (mul_start),
		.alu_op      (alu_op),
		.src_a       (src_a),
		.src_b       (src_b),
		.mul_busy    (mul_busy),
		.mul_done    (mul_done),
		.mul_product (mul_product)
	);

	exec_pipe_reg u_pipe_reg (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.alu_op         (alu_op),
		.alu_result     (alu_result),
		.mul_busy       (mul_busy),
		.mul_done       (mul_done),
		.mul_product    (mul_product),
		.mul_start      (mul_start),
		.pc             (pc),
		.store_data     (store_data),
		.mem_write      (mem_write),
		.wb_sel         (wb_sel),
		.reg_write      (reg_write),
		.rdest          (rdest),
		.out_ready      (out_ready),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_result     (out_result),
		.out_store_data (out_store_data),
		.out_mem_write  (out_mem_write),
		.out_wb_sel     (out_wb_sel),
		.out_reg_write  (out_reg_write),
		.out_rdest      (out_rdest)
	);

endmodule

// ==== hdl/exec_pipe_reg.sv ====
`timescale 1ns/1ps

module exec_pipe_reg (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           in_valid,
	output logic                           in_ready,
	input  logic [exec_pkg::op_w-1:0]      alu_op,
	input  exec_pkg::exec_word_u           alu_result,
	input  logic                           mul_busy,
	input  logic                           mul_done,
	input  exec_pkg::exec_word_u           mul_product,
	output logic                           mul_start,
	input  logic [exec_pkg::addr_w-1:0]    pc,
	input  logic [exec_pkg::xlen-1:0]      store_data,
	input  logic                           mem_write,
	input  logic                           wb_sel,
	input  logic                           reg_write,
	input  logic [exec_pkg::reg_idx_w-1:0] rdest,
	input  logic                           out_ready,
	output logic                           out_valid,
	output logic [exec_pkg::addr_w-1:0]    out_pc,
	output exec_pkg::exec_word_u           out_result,
	output logic [exec_pkg::xlen-1:0]      out_store_data,
	output logic                           out_mem_write,
	output logic                           out_wb_sel,
	output logic                           out_reg_write,
	output logic [exec_pkg::reg_idx_w-1:0] out_rdest
);

	import exec_pkg::*;

	logic                 is_mul;
	logic                 accept;
	logic                 load_ok;   // output slot free this edge
	logic                 mul_load;
	logic                 mul_wait;  // multiply accepted, not yet in output reg
	logic [addr_w-1:0]    hold_pc;
	logic [xlen-1:0]      hold_store_data;
	logic                 hold_mem_write;
	logic                 hold_wb_sel;
	logic                 hold_reg_write;
	logic [reg_idx_w-1:0] hold_rdest;

	assign is_mul = (alu_op == op_mul) | (alu_op == op_mulh) |
		(alu_op == op_mulhu) | (alu_op == op_mulw);
	assign load_ok   = ~out_valid | out_ready;
	assign in_ready  = ~mul_wait & ~mul_busy & load_ok;
	assign accept    = in_valid & in_ready;
	assign mul_start = accept & is_mul;
	assign mul_load  = mul_wait & mul_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			mul_wait <= 1'b0;
		end else begin
			if (mul_start) begin
				mul_wait <= 1'b1;
			end else if (mul_load) begin
				mul_wait <= 1'b0;
			end
			if ((accept & ~is_mul) | mul_load) begin
				out_valid <= 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	// sideband parked for the length of a multiply
	always_ff @(posedge clk) begin
		if (mul_start) begin
			hold_pc <= pc;
			hold_store_data <= store_data;
			hold_mem_write <= mem_write;
			hold_wb_sel <= wb_sel;
			hold_reg_write <= reg_write;
			hold_rdest <= rdest;
		end
	end

	always_ff @(posedge clk) begin
		if (accept & ~is_mul) begin
			out_pc <= pc;
			out_result <= alu_result;
			out_store_data <= store_data;
			out_mem_write <= mem_write;
			out_wb_sel <= wb_sel;
			out_reg_write <= reg_write;
			out_rdest <= rdest;
		end else if (mul_load) begin
			out_pc <= hold_pc;
			out_result <= mul_product;
			out_store_data <= hold_store_data;
			out_mem_write <= hold_mem_write;
			out_wb_sel <= hold_wb_sel;
			out_reg_write <= hold_reg_write;
			out_rdest <= hold_rdest;
		end
	end

	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_result) &&
		$stable(out_store_data) &&
		$stable({out_mem_write, out_wb_sel, out_reg_write, out_rdest}));

	a_done_pending: assert property (@(posedge clk) disable iff (reset)
		mul_done |-> mul_wait);

endmodule

// ==== hdl/exec_mul.sv ====
`timescale 1ns/1ps

module exec_mul (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      mul_start,
	input  logic [exec_pkg::op_w-1:0] alu_op,
	input  logic [exec_pkg::xlen-1:0] src_a,
	input  logic [exec_pkg::xlen-1:0] src_b,
	output logic                      mul_busy,
	output logic                      mul_done,
	output exec_pkg::exec_word_u      mul_product
);

	import exec_pkg::*;

	logic                   signed_op;
	logic                   neg_a;
	logic                   neg_b;
	logic [xlen-1:0]        mag_a;
	logic [xlen-1:0]        mag_b;
	logic [op_w-1:0]        op_q;
	logic                   neg_q;     // product sign
	logic [2*xlen-1:0]      mcand;
	logic [xlen-1:0]        mplier;
	logic [2*xlen-1:0]      acc;
	logic [2*xlen-1:0]      prod_full;
	logic [mul_cnt_w-1:0]   cnt;
	logic                   busy_q;
	logic                   done_q;

	// mulw only keeps the low word, so a signed 64-bit pass is enough
	assign signed_op = (alu_op == op_mulh) | (alu_op == op_mulw);
	assign neg_a = signed_op & src_a[xlen-1];
	assign neg_b = signed_op & src_b[xlen-1];
	assign mag_a = neg_a ? -src_a : src_a;
	assign mag_b = neg_b ? -src_b : src_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (mul_start) begin
				busy_q <= 1'b1;
				cnt <= '0;
			end else if (busy_q) begin
				cnt <= cnt + 1'b1;
				if (cnt == mul_cnt_w'(mul_iters - 1)) begin
					busy_q <= 1'b0;
					done_q <= 1'b1; // one-cycle pulse
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start) begin
			op_q <= alu_op;
			neg_q <= neg_a ^ neg_b;
			mcand <= {{xlen{1'b0}}, mag_a};
			mplier <= mag_b;
			acc <= '0;
		end else if (busy_q) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// acc stays put after done until the next start
	assign prod_full = neg_q ? -acc : acc;

	always_comb begin
		mul_product = '0;
		case (op_q)
			op_mul:            mul_product.dword = prod_full[xlen-1:0];
			op_mulh, op_mulhu: mul_product.dword = prod_full[2*xlen-1:xlen];
			op_mulw: begin
				mul_product.half.lower = prod_full[xlen/2-1:0];
				mul_product.half.upper = {(xlen/2){prod_full[xlen/2-1]}};
			end
			default: mul_product = '0;
		endcase
	end

	assign mul_busy = busy_q | done_q;
	assign mul_done = done_q;

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		mul_start |-> !mul_busy);

endmodule

// ==== hdl/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu (
	input  logic [exec_pkg::op_w-1:0]   alu_op,
	input  logic [exec_pkg::xlen-1:0]   src_a,
	input  logic [exec_pkg::xlen-1:0]   src_b,
	input  logic [exec_pkg::addr_w-1:0] pc,
	input  logic                        is_branch,
	input  logic [exec_pkg::bimm_w-1:0] branch_imm,
	output exec_pkg::exec_word_u        alu_result,
	output logic                        branch_taken,
	output logic [exec_pkg::addr_w-1:0] branch_target
);

	import exec_pkg::*;

	logic word_op; // result sits in lower half

	always_comb begin
		alu_result = '0;
		word_op = 1'b0;
		case (alu_op)
			op_add: alu_result.dword = src_a + src_b;
			op_addw: begin
				alu_result.half.lower = src_a[31:0] + src_b[31:0];
				word_op = 1'b1;
			end
			op_sll: alu_result.dword = src_a << src_b[5:0];
			op_sllw: begin
				alu_result.half.lower = src_a[31:0] << src_b[4:0];
				word_op = 1'b1;
			end
			op_sra: alu_result.dword = $signed(src_a) >>> src_b[5:0];
			op_sraw: begin
				alu_result.half.lower = $signed(src_a[31:0]) >>> src_b[4:0];
				word_op = 1'b1;
			end
			op_srl: alu_result.dword = src_a >> src_b[5:0];
			op_srlw: begin
				alu_result.half.lower = src_a[31:0] >> src_b[4:0];
				word_op = 1'b1;
			end
			op_and: alu_result.dword = src_a & src_b;
			op_or:  alu_result.dword = src_a | src_b;
			op_xor: alu_result.dword = src_a ^ src_b;
			op_slt: begin
				alu_result.dword = {{(xlen-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
			end
			op_sltu: begin
				alu_result.dword = {{(xlen-1){1'b0}}, (src_a < src_b)};
			end
			op_eq: begin
				alu_result.dword = {{(xlen-1){1'b0}}, (src_a == src_b)};
			end
			op_ne: begin
				alu_result.dword = {{(xlen-1){1'b0}}, (src_a != src_b)};
			end
			op_ge: begin
				alu_result.dword = {{(xlen-1){1'b0}}, ($signed(src_a) >= $signed(src_b))};
			end
			op_geu: begin
				alu_result.dword = {{(xlen-1){1'b0}}, (src_a >= src_b)};
			end
			op_sub: alu_result.dword = src_a - src_b;
			op_subw: begin
				alu_result.half.lower = src_a[31:0] - src_b[31:0];
				word_op = 1'b1;
			end
			default: alu_result = '0; // multiply handled elsewhere, others unused
		endcase
		if (word_op) begin
			alu_result.half.upper = {(xlen/2){alu_result.half.lower[xlen/2-1]}};
		end
	end

	// target is pc + sext(imm) * 2
	assign branch_target = pc + {{(addr_w-bimm_w-1){branch_imm[bimm_w-1]}}, branch_imm, 1'b0};
	assign branch_taken  = is_branch & (|alu_result.dword);

endmodule

// ==== hdl/exec_pkg.sv ====
package exec_pkg;

	// datapath widths
	localparam int xlen      = 64;
	localparam int addr_w    = 64;
	localparam int op_w      = 5;
	localparam int reg_idx_w = 5;
	localparam int bimm_w    = 12; // offset bits 12..1

	// single-cycle operations
	localparam logic [op_w-1:0] op_add   = 5'd0;
	localparam logic [op_w-1:0] op_addw  = 5'd1;
	localparam logic [op_w-1:0] op_sll   = 5'd2;
	localparam logic [op_w-1:0] op_sllw  = 5'd3;
	localparam logic [op_w-1:0] op_sra   = 5'd4;
	localparam logic [op_w-1:0] op_sraw  = 5'd5;
	localparam logic [op_w-1:0] op_srl   = 5'd6;
	localparam logic [op_w-1:0] op_srlw  = 5'd7;
	localparam logic [op_w-1:0] op_and   = 5'd8;
	localparam logic [op_w-1:0] op_or    = 5'd9;
	localparam logic [op_w-1:0] op_xor   = 5'd10;
	localparam logic [op_w-1:0] op_slt   = 5'd11;
	localparam logic [op_w-1:0] op_sltu  = 5'd12;
	localparam logic [op_w-1:0] op_eq    = 5'd13;
	localparam logic [op_w-1:0] op_ne    = 5'd14;
	localparam logic [op_w-1:0] op_ge    = 5'd15;
	localparam logic [op_w-1:0] op_geu   = 5'd16;
	localparam logic [op_w-1:0] op_sub   = 5'd17;
	localparam logic [op_w-1:0] op_subw  = 5'd18;

	// multi-cycle multiply
	localparam logic [op_w-1:0] op_mul   = 5'd19; // low 64, unsigned
	localparam logic [op_w-1:0] op_mulh  = 5'd20; // high 64, signed x signed
	localparam logic [op_w-1:0] op_mulhu = 5'd21; // high 64, unsigned
	localparam logic [op_w-1:0] op_mulw  = 5'd22; // low 32, sign extended

	// shift-add multiplier
	localparam int mul_iters = 64;
	localparam int mul_cnt_w = $clog2(mul_iters);

	// result word, seen whole or as two 32-bit halves
	typedef union packed {
		logic [xlen-1:0] dword;
		struct packed {
			logic [xlen/2-1:0] upper;
			logic [xlen/2-1:0] lower; // word ops fill this
		} half;
	} exec_word_u;

endpackage
